// File: verif/bridge_vectors.txt
# op: 0 icache read, 1 dcache read, 2 dcache write, 3 both read, 4 write then read
# op  addr  type_or_strb  wdata_or_icache_addr  exp0  exp1  exp2  exp3 (all hex)
0 00000010 0 00000000 a5a50004 00000000 00000000 00000000
0 00000020 4 00000000 a5a50008 a5a50009 a5a5000a a5a5000b
2 00000030 3 11223344 00000000 00000000 00000000 00000000
1 00000030 0 00000000 a5a53344 00000000 00000000 00000000
3 00000040 0 00000050 a5a50010 a5a50014 00000000 00000000
4 00000060 c aabbccdd aabb0018 00000000 00000000 00000000
1 00000060 4 00000000 aabb0018 a5a50019 a5a5001a a5a5001b
1 00000084 1 00000000 a5a50021 00000000 00000000 00000000
2 00000100 f 12345678 00000000 00000000 00000000 00000000
0 00000100 0 00000000 12345678 00000000 00000000 00000000
2 00000104 1 000000ee 00000000 00000000 00000000 00000000
0 00000100 4 00000000 12345678 a5a500ee a5a50042 a5a50043
4 00000200 8 99000000 99a50080 00000000 00000000 00000000
3 00000300 0 00000304 a5a500c0 a5a500c1 00000000 00000000
0 000003f0 4 00000000 a5a500fc a5a500fd a5a500fe a5a500ff
1 00000008 0 00000000 a5a50002 00000000 00000000 00000000
1 0000003c 4 00000000 a5a53344 a5a5000d a5a5000e a5a5000f
2 00000010 6 deadbeef 00000000 00000000 00000000 00000000
0 00000010 0 00000000 a5adbe04 00000000 00000000 00000000

// File: compile.f
rtl/axi_bus_pkg.sv
rtl/cache_port_pkg.sv
rtl/read_request_fsm.sv
rtl/read_beat_counter.sv
rtl/read_return_buffer.sv
rtl/write_channel.sv
rtl/axi_cache_bridge.sv
verif/axi_cache_bridge_assertions.sv
verif/axi_cache_bridge_tb.sv

// File: Bender.yml
package:
  name: axi_cache_bridge

sources:
  - rtl/axi_bus_pkg.sv
  - rtl/cache_port_pkg.sv
  - rtl/read_request_fsm.sv
  - rtl/read_beat_counter.sv
  - rtl/read_return_buffer.sv
  - rtl/write_channel.sv
  - rtl/axi_cache_bridge.sv
  - target: test
    files:
      - verif/axi_cache_bridge_assertions.sv
      - verif/axi_cache_bridge_tb.sv

// File: verif/axi_cache_bridge_tb.sv
`timescale 1ns/1ns

module axi_cache_bridge_tb
    import axi_bus_pkg::*, cache_port_pkg::*;
;

    logic      aclk, aresetn;
    logic      icache_rd_req, dcache_rd_req, dcache_wr_req;
    rd_req_t   icache_rd, dcache_rd;
    wr_req_t   dcache_wr;
    logic      icache_rd_rdy, dcache_rd_rdy, dcache_wr_rdy;
    logic      icache_ret_valid, icache_ret_last, dcache_ret_valid, dcache_ret_last;
    axi_data_t icache_ret_data, dcache_ret_data;
    ar_chan_t  ar;
    logic      arvalid, arready, rvalid, rready;
    r_chan_t   r;
    aw_chan_t  aw;
    w_chan_t   w;
    logic      awvalid, awready, wvalid, wready, bvalid, bready;

    integer    seed = 135;
    int        errors = 0;
    int        cycles = 0;
    int        limit = 0;     // set once the vectors are counted
    axi_data_t mem [256];     // slave memory word k starts as k ^ a5a50000
    int        beat_idx_q[$]; // beats owed on R
    axi_id_t   beat_id_q[$];
    bit        beat_last_q[$];
    axi_id_t   ar_id_log[$];
    axi_len_t  ar_len_log[$];
    axi_addr_t ar_addr_log[$];
    axi_data_t iret_q[$], dret_q[$];
    bit        ilast_q[$], dlast_q[$];
    aw_chan_t  aw_got;
    w_chan_t   w_got;
    bit        aw_seen, w_seen, b_pend;
    int        ar_dly = -1, r_dly = -1, aw_dly = -1, w_dly = -1, b_dly = -1;
    bit        wr_busy;       // write taken, no B yet
    axi_addr_t haz_addr;
    int        vec_op[$];
    logic [31:0] vec_addr[$], vec_tos[$], vec_wdata[$], vec_exp[$];  // 4 exp per line

    axi_cache_bridge u_dut (.*);

    initial begin
        aclk = 1'b0;
        forever #2 aclk = ~aclk;
    end

    task automatic compare_value(input string name, input logic [31:0] got, exp);
        if (got !== exp) begin
            errors++;
            $display("MISMATCH %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic report_error(input string msg);
        errors++;
        $display("ERROR: %s", msg);
    endtask

    // random wait of 0..3 cycles with its own counter per channel
    function bit ready_after_delay(inout int cnt);
        if (cnt < 0) cnt = $random(seed) & 3;
        if (cnt == 0) begin
            cnt = -1;
            return 1'b1;
        end
        cnt--;
        return 1'b0;
    endfunction

    //////////////////////////////
    // AXI slave model
    //////////////////////////////

    initial begin : slave_model
        bit ar_hs, r_hs, aw_hs, w_hs, b_hs;
        int base;
        int idx;
        for (int k = 0; k < 256; k++) mem[k] = 32'ha5a5_0000 ^ k;
        forever begin
            @(posedge aclk);  // handshakes judged on pre-edge values
            ar_hs = arvalid && arready;
            r_hs  = rvalid && rready;
            aw_hs = awvalid && awready;
            w_hs  = wvalid && wready;
            b_hs  = bvalid && bready;
            if (ar_hs) begin
                if (beat_idx_q.size() != 0)
                    report_error("read address sent while a burst was still in flight");
                ar_id_log.push_back(ar.id);
                ar_len_log.push_back(ar.len);
                ar_addr_log.push_back(ar.addr);
                compare_value("ar.size", ar.size, SIZE_WORD);
                if (wr_busy && ar.addr == haz_addr)
                    report_error("read address sent while a write to it was pending");
                base = (ar.len != 0) ? {ar.addr[9:4], 2'b00} : ar.addr[9:2];  // lines aligned
                for (int b = 0; b <= ar.len; b++) begin
                    beat_idx_q.push_back(base + b);
                    beat_id_q.push_back(ar.id);
                    beat_last_q.push_back(b == ar.len);
                end
            end
            if (r_hs) begin
                void'(beat_idx_q.pop_front());
                void'(beat_id_q.pop_front());
                void'(beat_last_q.pop_front());
            end
            if (aw_hs) begin
                aw_got  = aw;
                aw_seen = 1'b1;
            end
            if (w_hs) begin
                w_got  = w;
                w_seen = 1'b1;
            end
            if (b_hs) wr_busy = 1'b0;
            #1;
            if (ar_hs) arready = 1'b0;
            else if (arvalid) arready = ready_after_delay(ar_dly);
            if (aw_hs) awready = 1'b0;
            else if (awvalid) awready = ready_after_delay(aw_dly);
            if (w_hs) wready = 1'b0;
            else if (wvalid) wready = ready_after_delay(w_dly);
            if (r_hs) rvalid = 1'b0;
            else if (!rvalid && beat_idx_q.size() > 0 && ready_after_delay(r_dly)) begin
                rvalid = 1'b1;
                r.id   = beat_id_q[0];
                r.data = mem[beat_idx_q[0] & 255];
                r.last = beat_last_q[0];
            end
            if (aw_seen && w_seen) begin  // merge by byte strobe
                idx = aw_got.addr[9:2];
                for (int l = 0; l < 4; l++)
                    if (w_got.strb[l]) mem[idx][8*l +: 8] = w_got.data[8*l +: 8];
                aw_seen = 1'b0;
                w_seen  = 1'b0;
                b_pend  = 1'b1;
            end
            if (b_hs) bvalid = 1'b0;
            else if (b_pend && ready_after_delay(b_dly)) begin
                bvalid = 1'b1;
                b_pend = 1'b0;
            end
        end
    end

    always @(posedge aclk) begin  // collect returned beats
        if (icache_ret_valid) begin
            iret_q.push_back(icache_ret_data);
            ilast_q.push_back(icache_ret_last);
        end
        if (dcache_ret_valid) begin
            dret_q.push_back(dcache_ret_data);
            dlast_q.push_back(dcache_ret_last);
        end
    end

    initial begin : watchdog
        wait (limit > 0);
        while (cycles < limit) begin
            @(posedge aclk);
            cycles++;
        end
        $display("ERROR: run did not finish within %0d cycles", limit);
        $display("Done: errors found");
        $finish;
    end

    //////////////////////////////
    // request drivers
    //////////////////////////////

    task automatic issue_read(input bit to_d, input rd_req_t req);
        if (to_d) begin
            dcache_rd     = req;
            dcache_rd_req = 1'b1;
        end else begin
            icache_rd     = req;
            icache_rd_req = 1'b1;
        end
        do @(posedge aclk); while (!(to_d ? dcache_rd_rdy : icache_rd_rdy));
        #1;
        if (to_d) dcache_rd_req = 1'b0;
        else icache_rd_req = 1'b0;
    endtask

    task automatic issue_write(input wr_req_t req);
        dcache_wr     = req;
        dcache_wr_req = 1'b1;
        do @(posedge aclk); while (!dcache_wr_rdy);
        #1;
        dcache_wr_req = 1'b0;
        wr_busy       = 1'b1;
        haz_addr      = req.addr;
    endtask

    // wr_rdy back means the whole write is over
    task automatic finish_write(input wr_req_t req);
        do @(posedge aclk); while (!dcache_wr_rdy);
        if (wr_busy) report_error("dcache_wr_rdy returned before the write response");
        compare_value("aw.addr", aw_got.addr, req.addr);
        compare_value("aw.size", aw_got.size, SIZE_WORD);
        compare_value("w.data", w_got.data, req.data);
        compare_value("w.strb", w_got.strb, req.strb);
        #1;
    endtask

    task automatic check_returns(input bit from_d, input int n, input int base_k);
        axi_data_t d;
        bit        l;
        while ((from_d ? dret_q.size() : iret_q.size()) < n) begin
            @(posedge aclk);
            #1;
        end
        for (int k = 0; k < n; k++) begin
            d = from_d ? dret_q.pop_front() : iret_q.pop_front();
            l = from_d ? dlast_q.pop_front() : ilast_q.pop_front();
            compare_value(from_d ? "dcache_ret_data" : "icache_ret_data",
                          d, vec_exp[base_k + k]);
            compare_value(from_d ? "dcache_ret_last" : "icache_ret_last", l, k == n - 1);
        end
    endtask

    task automatic check_ar(input int pos, input axi_id_t id, input axi_len_t len,
                            input axi_addr_t addr);
        if (ar_id_log.size() <= pos) begin
            report_error("expected read address transfer is missing");
        end else begin
            compare_value("ar.id", ar_id_log[pos], id);
            compare_value("ar.len", ar_len_log[pos], len);
            compare_value("ar.addr", ar_addr_log[pos], addr);
        end
    endtask

    //////////////////////////////
    // main sequence
    //////////////////////////////

    initial begin : main
        int          fd;
        string       line;
        int          op, nf, n;
        logic [31:0] a, t, wd, e0, e1, e2, e3;
        rd_req_t     rq;
        wr_req_t     wq;
        bit          d_pend, i_pend, d_acc, i_acc;
        aresetn = 1'b0;
        {icache_rd_req, dcache_rd_req, dcache_wr_req} = '0;
        icache_rd = '0;
        dcache_rd = '0;
        dcache_wr = '0;
        {arready, rvalid, awready, wready, bvalid} = '0;
        r = '0;
        fd = $fopen("verif/bridge_vectors.txt", "r");
        if (fd == 0) begin
            report_error("cannot open verif/bridge_vectors.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 0 && line.substr(0, 0) != "#") begin
                    nf = $sscanf(line, "%h %h %h %h %h %h %h %h",
                                 op, a, t, wd, e0, e1, e2, e3);
                    if (nf == 8) begin
                        vec_op.push_back(op);
                        vec_addr.push_back(a);
                        vec_tos.push_back(t);
                        vec_wdata.push_back(wd);
                        vec_exp.push_back(e0);
                        vec_exp.push_back(e1);
                        vec_exp.push_back(e2);
                        vec_exp.push_back(e3);
                    end
                end
            end
            $fclose(fd);
        end
        limit = 40 * vec_op.size() + 16;  // plus reset and margin
        repeat (4) @(posedge aclk);
        #1 aresetn = 1'b1;
        compare_value("arvalid", arvalid, 0);
        compare_value("awvalid", awvalid, 0);
        compare_value("wvalid", wvalid, 0);
        compare_value("rready", rready, 0);
        compare_value("bready", bready, 0);
        compare_value("icache_ret_valid", icache_ret_valid, 0);
        compare_value("dcache_ret_valid", dcache_ret_valid, 0);
        for (int i = 0; i < vec_op.size(); i++) begin
            ar_id_log.delete();
            ar_len_log.delete();
            ar_addr_log.delete();
            n = (rd_type_t'(vec_tos[i]) == RD_TYPE_LINE) ? LINE_BEATS : 1;
            rq.rtype = rd_type_t'(vec_tos[i]);
            rq.addr  = vec_addr[i];
            wq.addr  = vec_addr[i];
            wq.strb  = vec_tos[i][3:0];
            wq.data  = vec_wdata[i];
            case (vec_op[i])
                0, 1: begin  // single cache read
                    issue_read(vec_op[i] == 1, rq);
                    check_returns(vec_op[i] == 1, n, 4 * i);
                    check_ar(0, (vec_op[i] == 1) ? ID_DCACHE : ID_ICACHE, n - 1,
                             vec_addr[i]);
                end
                2: begin
                    issue_write(wq);
                    finish_write(wq);
                end
                3: begin  // both caches ask for one word in the same cycle
                    dcache_rd     = {3'b000, vec_addr[i]};
                    icache_rd     = {3'b000, vec_wdata[i]};
                    dcache_rd_req = 1'b1;
                    icache_rd_req = 1'b1;
                    d_pend        = 1'b1;
                    i_pend        = 1'b1;
                    while (d_pend || i_pend) begin
                        @(posedge aclk);
                        d_acc = d_pend && dcache_rd_rdy;
                        i_acc = i_pend && icache_rd_rdy;
                        #1;
                        if (i_acc && d_pend)
                            report_error("icache read taken before the dcache read");
                        if (d_acc) {dcache_rd_req, d_pend} = 2'b00;
                        if (i_acc) {icache_rd_req, i_pend} = 2'b00;
                    end
                    check_returns(1'b1, 1, 4 * i);
                    check_returns(1'b0, 1, 4 * i + 1);
                    check_ar(0, ID_DCACHE, 0, vec_addr[i]);
                    check_ar(1, ID_ICACHE, 0, vec_wdata[i]);
                end
                4: begin  // read right behind a write to the same word
                    issue_write(wq);
                    rq.rtype = '0;
                    issue_read(1'b1, rq);
                    check_returns(1'b1, 1, 4 * i);
                    finish_write(wq);
                end
                default: report_error("unknown operation in vector file");
            endcase
            if (iret_q.size() != 0 || dret_q.size() != 0)
                report_error("extra return beats after a vector");
        end
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: verif/axi_cache_bridge_assertions.sv
`timescale 1ns/1ns

module axi_cache_bridge_assertions
    import axi_bus_pkg::*;
(
    input logic     aclk,
    input logic     aresetn,
    input ar_chan_t ar,
    input logic     arvalid,
    input logic     arready,
    input aw_chan_t aw,
    input logic     awvalid,
    input logic     awready,
    input w_chan_t  w,
    input logic     wvalid,
    input logic     wready,
    input logic     rready,
    input logic     icache_ret_valid,
    input logic     dcache_ret_valid
);

    ///////////////////////////////
    // valid held until handshake
    ///////////////////////////////

    ar_hold: assert property (@(posedge aclk) disable iff (!aresetn)
        arvalid && !arready |=> arvalid && $stable(ar))
        else $error("arvalid dropped or ar changed before its handshake");

    aw_hold: assert property (@(posedge aclk) disable iff (!aresetn)
        awvalid && !awready |=> awvalid && $stable(aw))
        else $error("awvalid dropped or aw changed before its handshake");

    w_hold: assert property (@(posedge aclk) disable iff (!aresetn)
        wvalid && !wready |=> wvalid && $stable(w))
        else $error("wvalid dropped or w changed before its handshake");

    // data phase opens only after the address went out
    no_early_rready: assert property (@(posedge aclk) disable iff (!aresetn)
        !(arvalid && rready))
        else $error("rready high while arvalid still waiting");

    one_return: assert property (@(posedge aclk) disable iff (!aresetn)
        !(icache_ret_valid && dcache_ret_valid))
        else $error("return valid sent to both caches at once");

endmodule

bind axi_cache_bridge axi_cache_bridge_assertions u_assertions (.*);

// File: rtl/axi_cache_bridge.sv
`timescale 1ns/1ns

module axi_cache_bridge
    import axi_bus_pkg::*, cache_port_pkg::*;
(
    input  logic      aclk,
    input  logic      aresetn,
    // instruction cache reads
    input  logic      icache_rd_req,
    input  rd_req_t   icache_rd,
    output logic      icache_rd_rdy,
    output logic      icache_ret_valid,
    output logic      icache_ret_last,
    output axi_data_t icache_ret_data,
    // data cache reads
    input  logic      dcache_rd_req,
    input  rd_req_t   dcache_rd,
    output logic      dcache_rd_rdy,
    output logic      dcache_ret_valid,
    output logic      dcache_ret_last,
    output axi_data_t dcache_ret_data,
    // data cache writes
    input  logic      dcache_wr_req,
    input  wr_req_t   dcache_wr,
    output logic      dcache_wr_rdy,
    // AXI read
    output ar_chan_t  ar,
    output logic      arvalid,
    input  logic      arready,
    input  r_chan_t   r,
    input  logic      rvalid,
    output logic      rready,
    // AXI write
    output aw_chan_t  aw,
    output logic      awvalid,
    input  logic      awready,
    output w_chan_t   w,
    output logic      wvalid,
    input  logic      wready,
    input  logic      bvalid,
    output logic      bready
);

    logic     burst_start;
    axi_len_t burst_len;
    logic     burst_busy;
    logic     last_beat;
    logic     beat_done;
    logic     wr_pending;
    aw_chan_t wr_pend_aw;

    assign rready    = burst_busy;          // open only during a burst
    assign beat_done = rvalid && rready;

    ///////////////////////////////
    // read path
    ///////////////////////////////

    read_request_fsm u_read_request_fsm (
        .aclk, .aresetn,
        .icache_rd_req, .icache_rd, .dcache_rd_req, .dcache_rd,
        .wr_pending, .wr_pend_aw, .burst_busy,
        .icache_rd_rdy, .dcache_rd_rdy,
        .ar, .arvalid, .arready,
        .burst_start, .burst_len
    );

    read_beat_counter u_read_beat_counter (
        .aclk, .aresetn,
        .burst_start, .burst_len, .beat_done,
        .busy      (burst_busy),
        .last_beat
    );

    read_return_buffer u_read_return_buffer (
        .aclk, .aresetn,
        .r, .beat_done, .last_beat,
        .icache_ret_valid, .icache_ret_last, .icache_ret_data,
        .dcache_ret_valid, .dcache_ret_last, .dcache_ret_data
    );

    ///////////////////////////////
    // write path
    ///////////////////////////////

    write_channel u_write_channel (
        .aclk, .aresetn,
        .dcache_wr_req, .dcache_wr, .dcache_wr_rdy,
        .aw, .awvalid, .awready,
        .w, .wvalid, .wready,
        .bvalid, .bready,
        .wr_pending, .wr_pend_aw
    );

endmodule

// File: rtl/write_channel.sv
`timescale 1ns/1ns

module write_channel
    import axi_bus_pkg::*, cache_port_pkg::*;
(
    input  logic     aclk,
    input  logic     aresetn,
    // data cache write port
    input  logic     dcache_wr_req,
    input  wr_req_t  dcache_wr,
    output logic     dcache_wr_rdy,
    // AXI write address and data
    output aw_chan_t aw,
    output logic     awvalid,
    input  logic     awready,
    output w_chan_t  w,
    output logic     wvalid,
    input  logic     wready,
    // AXI write response
    input  logic     bvalid,
    output logic     bready,
    // hazard info for the read side
    output logic     wr_pending,
    output aw_chan_t wr_pend_aw
);

    wr_state_e state_q, state_d;
    aw_chan_t  aw_q;
    w_chan_t   w_q;
    logic      take;
    logic      aw_hs;
    logic      w_hs;

    assign take  = dcache_wr_req && dcache_wr_rdy;
    assign aw_hs = awvalid && awready;
    assign w_hs  = wvalid && wready;

    ///////////////////////////////
    // state machine
    ///////////////////////////////

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            state_q <= WR_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            WR_IDLE: if (take) state_d = WR_BOTH;
            WR_BOTH: begin  // either channel may finish first
                if (aw_hs && w_hs) state_d = WR_RESP;
                else if (aw_hs)    state_d = WR_ADDR_DONE;
                else if (w_hs)     state_d = WR_DATA_DONE;
            end
            WR_ADDR_DONE: if (w_hs)   state_d = WR_RESP;
            WR_DATA_DONE: if (aw_hs)  state_d = WR_RESP;
            WR_RESP:      if (bvalid) state_d = WR_IDLE;  // bready high here
            default:      state_d = WR_IDLE;
        endcase
    end

    // payload latched once per write, held until both handshakes
    always_ff @(posedge aclk) begin
        if (take) begin
            aw_q.addr <= dcache_wr.addr;
            aw_q.size <= SIZE_WORD;  // always one word
            w_q.data  <= dcache_wr.data;
            w_q.strb  <= dcache_wr.strb;
        end
    end

    assign dcache_wr_rdy = (state_q == WR_IDLE);
    assign awvalid       = (state_q == WR_BOTH) || (state_q == WR_DATA_DONE);
    assign wvalid        = (state_q == WR_BOTH) || (state_q == WR_ADDR_DONE);
    assign bready        = (state_q == WR_RESP);
    assign aw            = aw_q;
    assign w             = w_q;

    // pending until the cycle after the B handshake
    assign wr_pending = (state_q != WR_IDLE);
    assign wr_pend_aw = aw_q;

endmodule

// File: rtl/read_return_buffer.sv
`timescale 1ns/1ns

module read_return_buffer
    import axi_bus_pkg::*;
(
    input  logic      aclk,
    input  logic      aresetn,
    input  r_chan_t   r,
    input  logic      beat_done,  // rvalid and rready
    input  logic      last_beat,
    output logic      icache_ret_valid,
    output logic      icache_ret_last,
    output axi_data_t icache_ret_data,
    output logic      dcache_ret_valid,
    output logic      dcache_ret_last,
    output axi_data_t dcache_ret_data
);

    axi_data_t i_data_q;  // one holding register per read id
    axi_data_t d_data_q;
    logic      to_icache;
    logic      to_dcache;

    assign to_icache = beat_done && (r.id == ID_ICACHE);
    assign to_dcache = beat_done && (r.id == ID_DCACHE);  // other ids dropped

    ///////////////////////////////
    // data capture
    ///////////////////////////////

    always_ff @(posedge aclk) begin
        if (to_icache) i_data_q <= r.data;
        if (to_dcache) d_data_q <= r.data;
    end

    // valid and last pulse the cycle after the beat
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            icache_ret_valid <= 1'b0;
            icache_ret_last  <= 1'b0;
            dcache_ret_valid <= 1'b0;
            dcache_ret_last  <= 1'b0;
        end else begin
            icache_ret_valid <= to_icache;
            icache_ret_last  <= to_icache && last_beat;
            dcache_ret_valid <= to_dcache;
            dcache_ret_last  <= to_dcache && last_beat;
        end
    end

    assign icache_ret_data = i_data_q;
    assign dcache_ret_data = d_data_q;

endmodule

// File: rtl/read_beat_counter.sv
`timescale 1ns/1ns

module read_beat_counter
    import axi_bus_pkg::*, cache_port_pkg::*;
(
    input  logic     aclk,
    input  logic     aresetn,
    input  logic     burst_start,  // AR handshake
    input  axi_len_t burst_len,    // beats minus one
    input  logic     beat_done,    // R handshake
    output logic     busy,
    output logic     last_beat
);

    // beats still to come after the current one, a line at most
    logic [$clog2(LINE_BEATS)-1:0] remain_q;
    logic                          busy_q;

    ///////////////////////////////
    // beat count
    ///////////////////////////////

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            busy_q   <= 1'b0;
            remain_q <= '0;
        end else if (burst_start) begin
            busy_q   <= 1'b1;
            remain_q <= burst_len[$clog2(LINE_BEATS)-1:0];  // len never exceeds a line
        end else if (beat_done && busy_q) begin
            if (remain_q == '0) begin
                busy_q <= 1'b0;  // burst complete
            end else begin
                remain_q <= remain_q - 1'b1;
            end
        end
    end

    // rready comes from here, so beats only land while busy
    assign busy      = busy_q;
    assign last_beat = busy_q && (remain_q == '0);  // sampled with beat_done

endmodule

// File: rtl/read_request_fsm.sv
`timescale 1ns/1ns

module read_request_fsm
    import axi_bus_pkg::*, cache_port_pkg::*;
(
    input  logic     aclk,
    input  logic     aresetn,
    // cache requests
    input  logic     icache_rd_req,
    input  rd_req_t  icache_rd,
    input  logic     dcache_rd_req,
    input  rd_req_t  dcache_rd,
    // status from the write side and the beat counter
    input  logic     wr_pending,
    input  aw_chan_t wr_pend_aw,
    input  logic     burst_busy,
    output logic     icache_rd_rdy,
    output logic     dcache_rd_rdy,
    // AXI read address
    output ar_chan_t ar,
    output logic     arvalid,
    input  logic     arready,
    // to the beat counter
    output logic     burst_start,
    output axi_len_t burst_len
);

    ar_state_e state_q, state_d;
    ar_chan_t  ar_q;
    logic      rd_free;    // idle and nothing in flight
    logic      i_hazard;   // icache address hits the pending write
    logic      d_hazard;
    logic      i_take;
    logic      d_take;

    ///////////////////////////////
    // accept and hazard logic
    ///////////////////////////////

    assign rd_free  = (state_q == AR_IDLE) && !burst_busy;
    assign i_hazard = wr_pending && (icache_rd.addr == wr_pend_aw.addr);
    assign d_hazard = wr_pending && (dcache_rd.addr == wr_pend_aw.addr);

    assign dcache_rd_rdy = rd_free && !d_hazard;
    assign icache_rd_rdy = rd_free && !i_hazard && !dcache_rd_req;  // dcache wins

    assign d_take = dcache_rd_req && dcache_rd_rdy;
    assign i_take = icache_rd_req && icache_rd_rdy;  // never together with d_take

    ///////////////////////////////
    // state machine
    ///////////////////////////////

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            state_q <= AR_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            AR_IDLE:  if (d_take || i_take) state_d = AR_ISSUE;
            AR_ISSUE: if (arready)          state_d = AR_DONE;  // arvalid is high here
            AR_DONE:  state_d = AR_IDLE;
            default:  state_d = AR_IDLE;
        endcase
    end

    // payload, loaded only at acceptance so it holds through the stall
    always_ff @(posedge aclk) begin
        if (d_take) begin
            ar_q.id   <= ID_DCACHE;
            ar_q.addr <= dcache_rd.addr;
            ar_q.len  <= (dcache_rd.rtype == RD_TYPE_LINE) ? axi_len_t'(LINE_BEATS - 1) : '0;
            ar_q.size <= SIZE_WORD;
        end else if (i_take) begin
            ar_q.id   <= ID_ICACHE;
            ar_q.addr <= icache_rd.addr;
            ar_q.len  <= (icache_rd.rtype == RD_TYPE_LINE) ? axi_len_t'(LINE_BEATS - 1) : '0;
            ar_q.size <= SIZE_WORD;
        end
    end

    assign ar          = ar_q;
    assign arvalid     = (state_q == AR_ISSUE);
    assign burst_start = arvalid && arready;  // one cycle, on the handshake
    assign burst_len   = ar_q.len;

endmodule

// File: rtl/cache_port_pkg.sv
package cache_port_pkg;
    import axi_bus_pkg::*;

    ///////////////////////////////
    // cache side request types
    ///////////////////////////////

    typedef logic [2:0] rd_type_t;  // 100 = cache line, else one word

    localparam rd_type_t RD_TYPE_LINE = 3'b100;
    localparam int       LINE_BEATS   = 4;  // words per cache line

    typedef struct packed {
        rd_type_t  rtype;
        axi_addr_t addr;
    } rd_req_t;  // 35 bits

    typedef struct packed {
        axi_addr_t addr;
        axi_strb_t strb;  // byte enables of the word
        axi_data_t data;
    } wr_req_t;  // 68 bits

    ///////////////////////////////
    // state machines
    ///////////////////////////////

    typedef enum logic [1:0] {
        AR_IDLE,   // waiting for a cache request
        AR_ISSUE,  // arvalid up
        AR_DONE    // one cycle after the AR handshake
    } ar_state_e;

    typedef enum logic [2:0] {
        WR_IDLE,
        WR_BOTH,       // aw and w both outstanding
        WR_ADDR_DONE,  // aw taken, w still waiting
        WR_DATA_DONE,  // w taken, aw still waiting
        WR_RESP        // waiting on bvalid
    } wr_state_e;

endpackage

// File: rtl/axi_bus_pkg.sv
package axi_bus_pkg;

    ///////////////////////////////
    // plain AXI field widths
    ///////////////////////////////

    typedef logic [31:0] axi_addr_t;  // byte address
    typedef logic [31:0] axi_data_t;  // one beat, 32-bit bus
    typedef logic [3:0]  axi_strb_t;  // one bit per byte lane
    typedef logic [3:0]  axi_id_t;
    typedef logic [7:0]  axi_len_t;   // beats minus one
    typedef logic [2:0]  axi_size_t;  // log2 bytes per beat

    ///////////////////////////////
    // channel payloads
    ///////////////////////////////

    typedef struct packed {
        axi_id_t   id;    // which cache asked
        axi_addr_t addr;
        axi_len_t  len;
        axi_size_t size;
    } ar_chan_t;  // 47 bits

    typedef struct packed {
        axi_addr_t addr;
        axi_size_t size;
    } aw_chan_t;  // id, len, burst fixed on the slave side

    typedef struct packed {
        axi_data_t data;
        axi_strb_t strb;
    } w_chan_t;  // single beat, wlast implied

    typedef struct packed {
        axi_id_t   id;
        axi_data_t data;
        logic      last;  // carried only, bridge counts beats itself
    } r_chan_t;

    // fixed encodings
    localparam axi_size_t SIZE_WORD = 3'b010;  // 4 bytes
    localparam axi_id_t   ID_ICACHE = 4'd0;
    localparam axi_id_t   ID_DCACHE = 4'd1;

endpackage
